//--- hdl/lc3b_pkg.sv
package lc3b_pkg;

	// buffer depths and credit pools
	localparam int INST_DEPTH = 4;
	localparam int RES_DEPTH = 4;
	localparam int RES_CREDITS = 2;

	// counter widths sized to hold the full pool
	localparam int SLOT_CNT_W = $clog2(RES_DEPTH + 1);
	localparam int RES_CNT_W = $clog2(RES_CREDITS + 1);

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// one-hot n, z, p from msb to lsb
	typedef logic [2:0] lc3b_nzp;

	typedef enum logic [3:0] {
		op_add = 4'd1,
		op_and = 4'd5,
		op_not = 4'd9,
		op_shf = 4'd13
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_pass,
		alu_add,
		alu_and,
		alu_not,
		alu_lshf,
		alu_rshfl,
		alu_rshfa
	} lc3b_alu_op;

	typedef struct packed {
		lc3b_alu_op alu_op;
		logic use_imm;
		logic ld_reg;
		logic ld_cc;
	} lc3b_control_word;

	typedef struct packed {
		lc3b_control_word cw;
		lc3b_reg dr;
		lc3b_reg sr1;
		lc3b_reg sr2;
		lc3b_word sr1_data;
		lc3b_word sr2_data;
		// sext(imm5) or zero-extended shift amount
		lc3b_word imm;
		logic valid;
	} lc3b_de_ex;

	typedef struct packed {
		lc3b_control_word cw;
		lc3b_reg dr;
		lc3b_word value;
		logic valid;
	} lc3b_ex_res;

	typedef struct packed {
		lc3b_reg dr;
		lc3b_word value;
		lc3b_nzp nzp;
		logic wrote;
	} lc3b_result_rec;

endpackage : lc3b_pkg

//--- hdl/credit_fifo.sv
module credit_fifo #(
	parameter type payload_t = logic [15:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic arst_n,
	input logic push,
	input payload_t wdata,
	input logic pop,
	output payload_t rdata,
	output logic empty
);

	payload_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic do_pop;

	assign empty = (count == '0);
	assign rdata = mem[rd_ptr];
	// a pop on an empty buffer is ignored
	assign do_pop = pop && !empty;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule : credit_fifo

//--- hdl/lc3b_regfile.sv
module lc3b_regfile (
	input logic clk,
	input logic arst_n,
	input logic we,
	input lc3b_pkg::lc3b_reg waddr,
	input lc3b_pkg::lc3b_word wdata,
	input lc3b_pkg::lc3b_reg raddr_a,
	input lc3b_pkg::lc3b_reg raddr_b,
	output lc3b_pkg::lc3b_word rdata_a,
	output lc3b_pkg::lc3b_word rdata_b
);
	import lc3b_pkg::*;

	lc3b_word regs [8];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// write-through so a same-cycle read sees the new value
	assign rdata_a = (we && waddr == raddr_a) ? wdata : regs[raddr_a];
	assign rdata_b = (we && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule : lc3b_regfile

//--- hdl/lc3b_decode.sv
module lc3b_decode (
	input logic clk,
	input logic arst_n,
	input logic inst_empty,
	input lc3b_pkg::lc3b_word inst_word,
	output logic inst_pop,
	input logic we,
	input lc3b_pkg::lc3b_reg waddr,
	input lc3b_pkg::lc3b_word wdata,
	input logic slot_release,
	output lc3b_pkg::lc3b_de_ex de_ex
);
	import lc3b_pkg::*;

	lc3b_opcode opcode;
	lc3b_control_word cw;
	lc3b_word imm;
	lc3b_reg dr;
	lc3b_reg sr1;
	lc3b_reg sr2;
	lc3b_word sr1_data;
	lc3b_word sr2_data;
	logic [SLOT_CNT_W-1:0] slot_cnt;
	logic issue;

	assign opcode = lc3b_opcode'(inst_word[15:12]);
	assign dr = inst_word[11:9];
	assign sr1 = inst_word[8:6];
	assign sr2 = inst_word[2:0];

	// issue only with a result slot reserved
	assign issue = !inst_empty && (slot_cnt != '0);
	assign inst_pop = issue;

	lc3b_regfile u_regfile (
		.clk,
		.arst_n,
		.we,
		.waddr,
		.wdata,
		.raddr_a(sr1),
		.raddr_b(sr2),
		.rdata_a(sr1_data),
		.rdata_b(sr2_data)
	);

	always_comb begin
		cw.alu_op = alu_pass;
		cw.use_imm = 1'b0;
		cw.ld_reg = 1'b0;
		cw.ld_cc = 1'b0;
		imm = {{11{inst_word[4]}}, inst_word[4:0]};
		case (opcode)
			op_add, op_and: begin
				cw.alu_op = (opcode == op_add) ? alu_add : alu_and;
				cw.use_imm = inst_word[5];
				cw.ld_reg = 1'b1;
				cw.ld_cc = 1'b1;
			end
			op_not: begin
				cw.alu_op = alu_not;
				cw.ld_reg = 1'b1;
				cw.ld_cc = 1'b1;
			end
			op_shf: begin
				// bit 4 picks right, bit 5 makes it arithmetic
				if (!inst_word[4])
					cw.alu_op = alu_lshf;
				else if (inst_word[5])
					cw.alu_op = alu_rshfa;
				else
					cw.alu_op = alu_rshfl;
				cw.use_imm = 1'b1;
				cw.ld_reg = 1'b1;
				cw.ld_cc = 1'b1;
				imm = {12'b0, inst_word[3:0]};
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			slot_cnt <= SLOT_CNT_W'(RES_DEPTH);
		else
			slot_cnt <= slot_cnt - SLOT_CNT_W'(issue) + SLOT_CNT_W'(slot_release);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			de_ex <= '0;
		end else begin
			de_ex <= '{cw: cw, dr: dr, sr1: sr1, sr2: sr2, sr1_data: sr1_data,
				sr2_data: sr2_data, imm: imm, valid: issue};
		end
	end

endmodule : lc3b_decode

//--- hdl/lc3b_execute.sv
module lc3b_execute (
	input logic clk,
	input logic arst_n,
	input lc3b_pkg::lc3b_de_ex de_ex,
	input logic we,
	input lc3b_pkg::lc3b_reg waddr,
	input lc3b_pkg::lc3b_word wdata,
	output lc3b_pkg::lc3b_ex_res ex_res
);
	import lc3b_pkg::*;

	logic ex_hit_a;
	logic ex_hit_b;
	logic wb_hit_a;
	logic wb_hit_b;
	lc3b_word op_a;
	lc3b_word op_b;
	lc3b_word operand_b;
	lc3b_word alu_out;

	assign ex_hit_a = ex_res.valid && ex_res.cw.ld_reg && (ex_res.dr == de_ex.sr1);
	assign ex_hit_b = ex_res.valid && ex_res.cw.ld_reg && (ex_res.dr == de_ex.sr2);
	assign wb_hit_a = we && (waddr == de_ex.sr1);
	assign wb_hit_b = we && (waddr == de_ex.sr2);

	// youngest producer wins
	always_comb begin
		op_a = de_ex.sr1_data;
		if (wb_hit_a)
			op_a = wdata;
		if (ex_hit_a)
			op_a = ex_res.value;
		op_b = de_ex.sr2_data;
		if (wb_hit_b)
			op_b = wdata;
		if (ex_hit_b)
			op_b = ex_res.value;
	end

	assign operand_b = de_ex.cw.use_imm ? de_ex.imm : op_b;

	always_comb begin
		case (de_ex.cw.alu_op)
			alu_add: alu_out = op_a + operand_b;
			alu_and: alu_out = op_a & operand_b;
			alu_not: alu_out = ~op_a;
			alu_lshf: alu_out = op_a << operand_b[3:0];
			alu_rshfl: alu_out = op_a >> operand_b[3:0];
			alu_rshfa: alu_out = $signed(op_a) >>> operand_b[3:0];
			default: alu_out = op_a;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ex_res <= '0;
		else
			ex_res <= '{cw: de_ex.cw, dr: de_ex.dr, value: alu_out, valid: de_ex.valid};
	end

endmodule : lc3b_execute

//--- hdl/lc3b_result.sv
module lc3b_result (
	input logic clk,
	input logic arst_n,
	input lc3b_pkg::lc3b_ex_res ex_res,
	output logic we,
	output lc3b_pkg::lc3b_reg waddr,
	output lc3b_pkg::lc3b_word wdata,
	output logic slot_release,
	output logic res_valid,
	output lc3b_pkg::lc3b_result_rec res,
	input logic res_credit
);
	import lc3b_pkg::*;

	lc3b_nzp gen_cc;
	lc3b_result_rec rec_in;
	lc3b_result_rec rec_head;
	logic rec_empty;
	logic send;
	logic [RES_CNT_W-1:0] out_cnt;

	always_comb begin
		if (ex_res.value[15])
			gen_cc = 3'b100;
		else if (ex_res.value == '0)
			gen_cc = 3'b010;
		else
			gen_cc = 3'b001;
	end

	assign rec_in = '{dr: ex_res.dr, value: ex_res.value,
		nzp: ex_res.cw.ld_cc ? gen_cc : 3'b000, wrote: ex_res.cw.ld_reg};

	credit_fifo #(
		.payload_t(lc3b_result_rec),
		.DEPTH(RES_DEPTH)
	) u_res_fifo (
		.clk,
		.arst_n,
		.push(ex_res.valid),
		.wdata(rec_in),
		.pop(send),
		.rdata(rec_head),
		.empty(rec_empty)
	);

	assign send = !rec_empty && (out_cnt != '0);
	// the slot frees as the record leaves
	assign slot_release = res_valid;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			we <= 1'b0;
			res_valid <= 1'b0;
			out_cnt <= RES_CNT_W'(RES_CREDITS);
		end else begin
			we <= ex_res.valid && ex_res.cw.ld_reg;
			res_valid <= send;
			out_cnt <= out_cnt - RES_CNT_W'(send) + RES_CNT_W'(res_credit);
		end
	end

	always_ff @(posedge clk) begin
		waddr <= ex_res.dr;
		wdata <= ex_res.value;
		if (send)
			res <= rec_head;
	end

endmodule : lc3b_result

//--- hdl/lc3b_core.sv
module lc3b_core (
	input logic clk,
	input logic arst_n,
	input logic inst_valid,
	input lc3b_pkg::lc3b_word inst,
	output logic inst_credit,
	output logic res_valid,
	output lc3b_pkg::lc3b_result_rec res,
	input logic res_credit
);
	import lc3b_pkg::*;

	logic inst_empty;
	lc3b_word inst_head;
	lc3b_de_ex de_ex;
	lc3b_ex_res ex_res;
	logic we;
	lc3b_reg waddr;
	lc3b_word wdata;
	logic slot_release;

	// each pop hands one credit back to the source
	credit_fifo #(
		.payload_t(lc3b_word),
		.DEPTH(INST_DEPTH)
	) u_inst_fifo (
		.clk,
		.arst_n,
		.push(inst_valid),
		.wdata(inst),
		.pop(inst_credit),
		.rdata(inst_head),
		.empty(inst_empty)
	);

	lc3b_decode u_decode (
		.clk,
		.arst_n,
		.inst_empty,
		.inst_word(inst_head),
		.inst_pop(inst_credit),
		.we,
		.waddr,
		.wdata,
		.slot_release,
		.de_ex
	);

	lc3b_execute u_execute (
		.clk,
		.arst_n,
		.de_ex,
		.we,
		.waddr,
		.wdata,
		.ex_res
	);

	lc3b_result u_result (
		.clk,
		.arst_n,
		.ex_res,
		.we,
		.waddr,
		.wdata,
		.slot_release,
		.res_valid,
		.res,
		.res_credit
	);

endmodule : lc3b_core

//--- tests/lc3b_core_checker.sv
module lc3b_core_checker (
	input logic clk,
	input logic arst_n,
	input logic inst_valid,
	input logic inst_credit,
	input logic res_valid,
	input lc3b_pkg::lc3b_result_rec res,
	input logic res_credit,
	input logic we,
	input logic slot_release
);
	import lc3b_pkg::*;

	int err_cnt = 0;
	int out_credits;
	int in_flight;

	// credits the core holds and words the source has outstanding
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_credits <= RES_CREDITS;
			in_flight <= 0;
		end else begin
			out_credits <= out_credits - int'(res_valid) + int'(res_credit);
			in_flight <= in_flight + int'(inst_valid) - int'(inst_credit);
		end
	end

	res_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
		res_valid |-> out_credits > 0)
	else begin
		$error("record sent while the core held no output credit");
		err_cnt++;
	end

	inst_within_depth: assert property (@(posedge clk) disable iff (!arst_n)
		in_flight inside {[0:INST_DEPTH]})
	else begin
		$error("input credits returned do not match the words sent");
		err_cnt++;
	end

	nzp_one_hot: assert property (@(posedge clk) disable iff (!arst_n)
		res_valid && res.wrote |-> $onehot(res.nzp))
	else begin
		$error("condition code of a written record is not one-hot");
		err_cnt++;
	end

	quiet_in_reset: assert property (@(posedge clk)
		!arst_n |-> !res_valid && !inst_credit && !we && !slot_release)
	else begin
		$error("control output high during reset");
		err_cnt++;
	end

endmodule : lc3b_core_checker

//--- tests/lc3b_core_tb.sv
module lc3b_core_tb;
	import lc3b_pkg::*;

	localparam int N_RANDOM = 200;
	// enough to fill the input buffer, the result buffer and the sink credits
	localparam int N_HOLD = INST_DEPTH + RES_DEPTH + RES_CREDITS;
	localparam int N_INST = 9 + 8 + N_HOLD + 4 + N_RANDOM;
	localparam int CYCLE_LIMIT = 40 * N_INST + 200;

	logic clk;
	logic arst_n;
	logic inst_valid;
	lc3b_word inst;
	logic inst_credit;
	logic res_valid;
	lc3b_result_rec res;
	logic res_credit;

	lc3b_word model_regs [8];
	lc3b_result_rec exp_q [$];
	lc3b_result_rec exp_rec;
	logic [15:0] lfsr = 16'd23903;
	string cur_test = "reset";
	int src_credits = INST_DEPTH;
	int owed = 0;
	logic hold_credit = 1'b0;
	logic credit_gaps = 1'b0;
	int cycles = 0;
	int rec_cnt = 0;
	int fail_cnt = 0;
	int test_cnt = 0;
	int test_recs;
	int test_fails;

	lc3b_core u_dut (.*);

	bind lc3b_core lc3b_core_checker u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [15:0] lfsr_bits(int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic lc3b_word reg_mode(lc3b_opcode op, lc3b_reg dr, lc3b_reg sr1,
			lc3b_reg sr2);
		return {op, dr, sr1, 3'b000, sr2};
	endfunction

	function automatic lc3b_word imm_mode(lc3b_opcode op, lc3b_reg dr, lc3b_reg sr1,
			logic [4:0] imm5);
		return {op, dr, sr1, 1'b1, imm5};
	endfunction

	function automatic lc3b_word not_inst(lc3b_reg dr, lc3b_reg sr);
		return {op_not, dr, sr, 6'h3f};
	endfunction

	// shift kind in bits 5:4 is 00 left, 01 logical right or 11 arithmetic right
	function automatic lc3b_word shift_inst(lc3b_reg dr, lc3b_reg sr, logic [1:0] kind,
			logic [3:0] amt);
		return {op_shf, dr, sr, kind, amt};
	endfunction

	function automatic lc3b_word random_inst();
		logic [3:0] ops [8];
		logic [2:0] sel;
		ops = '{op_add, op_and, op_not, op_shf, op_add, op_and, op_shf, 4'd3};
		sel = 3'(lfsr_bits(3));
		return {ops[sel], 12'(lfsr_bits(12))};
	endfunction

	// reference model updating the shadow registers in program order
	function automatic lc3b_result_rec predict(lc3b_word w);
		lc3b_result_rec r;
		lc3b_word a;
		lc3b_word b;
		lc3b_word v;
		a = model_regs[w[8:6]];
		b = w[5] ? {{11{w[4]}}, w[4:0]} : model_regs[w[2:0]];
		r.wrote = 1'b1;
		case (w[15:12])
			op_add: v = a + b;
			op_and: v = a & b;
			op_not: v = ~a;
			op_shf: begin
				if (!w[4])
					v = a << w[3:0];
				else if (w[5])
					v = $signed(a) >>> w[3:0];
				else
					v = a >> w[3:0];
			end
			default: begin
				// passes sr1 through, writes nothing
				v = a;
				r.wrote = 1'b0;
			end
		endcase
		r.dr = w[11:9];
		r.value = v;
		if (!r.wrote)
			r.nzp = 3'b000;
		else if (v[15])
			r.nzp = 3'b100;
		else if (v == '0)
			r.nzp = 3'b010;
		else
			r.nzp = 3'b001;
		if (r.wrote)
			model_regs[r.dr] = v;
		return r;
	endfunction

	always @(posedge clk) begin
		cycles++;
		if (arst_n && inst_credit)
			src_credits++;
		if (arst_n && res_valid) begin
			owed++;
			rec_cnt++;
			if (exp_q.size() == 0) begin
				$display("%s: a record arrived when none was expected", cur_test);
				fail_cnt++;
			end else begin
				exp_rec = exp_q.pop_front();
				assert (res == exp_rec)
				else begin
					$display(
						"FAILED %s: expected r%0d=%h nzp=%b wrote=%b, got r%0d=%h nzp=%b wrote=%b",
						cur_test, exp_rec.dr, exp_rec.value, exp_rec.nzp, exp_rec.wrote,
						res.dr, res.value, res.nzp, res.wrote);
					fail_cnt++;
				end
			end
		end
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles in %s", cycles, cur_test);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;
		inst_valid = 1'b0;
		res_credit = 1'b0;
		if (owed > 0 && !hold_credit && (!credit_gaps || lfsr_bits(1) == 16'd1)) begin
			res_credit = 1'b1;
			owed--;
		end
	endtask

	task automatic send(input lc3b_word word);
		while (src_credits == 0)
			next_cycle();
		inst = word;
		inst_valid = 1'b1;
		src_credits--;
		exp_q.push_back(predict(word));
		next_cycle();
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_recs = rec_cnt;
		test_fails = fail_cnt;
	endtask

	task automatic end_test();
		while (exp_q.size() != 0)
			next_cycle();
		test_cnt++;
		$display("%s: %0d records, %0d failures", cur_test, rec_cnt - test_recs,
			fail_cnt - test_fails);
	endtask

	initial begin
		int total_fails;
		arst_n = 1'b0;
		inst_valid = 1'b0;
		inst = '0;
		res_credit = 1'b0;
		for (int i = 0; i < 8; i++)
			model_regs[i] = '0;
		repeat (10) @(posedge clk);
		#2;
		arst_n = 1'b1;

		start_test("reset_idle");
		repeat (5) begin
			next_cycle();
			assert (!res_valid && !inst_credit)
			else begin
				$display("reset_idle: res_valid or inst_credit high with no input sent");
				fail_cnt++;
			end
		end
		end_test();

		start_test("alu_ops");
		send(imm_mode(op_and, 3'd1, 3'd1, 5'd0));
		send(imm_mode(op_add, 3'd1, 3'd1, 5'd12));
		send(imm_mode(op_add, 3'd2, 3'd2, 5'h17));
		send(reg_mode(op_add, 3'd3, 3'd1, 3'd2));
		send(reg_mode(op_and, 3'd4, 3'd2, 3'd1));
		send(not_inst(3'd5, 3'd1));
		send(shift_inst(3'd6, 3'd2, 2'b00, 4'd3));
		send(shift_inst(3'd6, 3'd2, 2'b01, 4'd2));
		send(shift_inst(3'd7, 3'd2, 2'b11, 4'd2));
		end_test();

		// first four issue back to back, so distances one and two hit forwarding
		start_test("forwarding");
		send(imm_mode(op_add, 3'd1, 3'd1, 5'd1));
		send(reg_mode(op_add, 3'd2, 3'd1, 3'd1));
		send(reg_mode(op_add, 3'd3, 3'd2, 3'd1));
		send(not_inst(3'd4, 3'd3));
		send(reg_mode(op_and, 3'd5, 3'd3, 3'd4));
		send(shift_inst(3'd6, 3'd4, 2'b11, 4'd1));
		send(reg_mode(op_add, 3'd7, 3'd6, 3'd5));
		send(imm_mode(op_add, 3'd7, 3'd7, 5'h1f));
		end_test();

		start_test("backpressure");
		hold_credit = 1'b1;
		for (int i = 0; i < N_HOLD; i++)
			send(imm_mode(op_add, lc3b_reg'(i), lc3b_reg'(i + 7), 5'(i + 1)));
		repeat (20) next_cycle();
		assert (rec_cnt - test_recs <= RES_CREDITS)
		else begin
			$display("backpressure: more records sent than the sink granted credits");
			fail_cnt++;
		end
		assert (src_credits == 0)
		else begin
			$display("backpressure: input credits kept returning with the buffers full");
			fail_cnt++;
		end
		hold_credit = 1'b0;
		end_test();

		start_test("unknown_op");
		send({4'd0, 3'd5, 3'd2, 6'h3f});
		send({4'd14, 3'd2, 3'd7, 6'h00});
		send(imm_mode(op_add, 3'd6, 3'd5, 5'd0));
		send(reg_mode(op_and, 3'd0, 3'd2, 3'd2));
		end_test();

		start_test("random");
		credit_gaps = 1'b1;
		repeat (N_RANDOM) begin
			send(random_inst());
			if (lfsr_bits(2) == 16'd0)
				next_cycle();
		end
		end_test();

		total_fails = fail_cnt + u_dut.u_checker.err_cnt;
		$display("%0d tests, %0d records checked, %0d failures", test_cnt, rec_cnt,
			total_fails);
		if (total_fails == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule : lc3b_core_tb

//--- files.f
hdl/lc3b_pkg.sv
hdl/credit_fifo.sv
hdl/lc3b_regfile.sv
hdl/lc3b_decode.sv
hdl/lc3b_execute.sv
hdl/lc3b_result.sv
hdl/lc3b_core.sv
tests/lc3b_core_checker.sv
tests/lc3b_core_tb.sv

//--- Bender.yml
package:
  name: lc3b_core

sources:
  - hdl/lc3b_pkg.sv
  - hdl/credit_fifo.sv
  - hdl/lc3b_regfile.sv
  - hdl/lc3b_decode.sv
  - hdl/lc3b_execute.sv
  - hdl/lc3b_result.sv
  - hdl/lc3b_core.sv
  - target: test
    files:
      - tests/lc3b_core_checker.sv
      - tests/lc3b_core_tb.sv
